// ==== rtl/regMapPkg.sv ====
package regMapPkg;

  // ******************************
  // AXI4-Lite bus
  // ******************************
  localparam int AxiAddrWidth = 8;
  localparam int AxiDataWidth = 32;

  localparam logic [1:0] RespOkay = 2'b00;

  // ******************************
  // control space offsets
  // ******************************
  localparam logic [AxiAddrWidth-1:0] RegVersion   = 8'h00;  // read only
  localparam logic [AxiAddrWidth-1:0] RegImageType = 8'h04;  // read only
  localparam logic [AxiAddrWidth-1:0] RegDacInSel  = 8'h08;  // three 2-bit fields
  localparam logic [AxiAddrWidth-1:0] RegDecInSel  = 8'h0C;
  localparam logic [AxiAddrWidth-1:0] RegSoftReset = 8'h10;  // write only, any data

  // width of each source-select field
  localparam int SelWidth = 2;

  // constant words returned on read
  localparam logic [AxiDataWidth-1:0] VersionNumber = 32'd433;
  localparam logic [AxiDataWidth-1:0] ImageTypeId   = 32'h0000_0002;  // trellis demod image

endpackage

// ==== rtl/signalPkg.sv ====
package signalPkg;

  // ******************************
  // sample and code widths
  // ******************************
  localparam int SampleWidth = 18;  // internal monitor word
  localparam int DemodWidth  = 14;  // raw demod word, padded with low zeros
  localparam int DacWidth    = 14;
  localparam int ModeWidth   = 5;
  localparam int DacSelWidth = 4;

  // demodulator mode codes
  localparam logic [ModeWidth-1:0] ModeFm         = 5'd1;
  localparam logic [ModeWidth-1:0] ModeBpsk       = 5'd3;
  localparam logic [ModeWidth-1:0] ModePcmTrellis = 5'd5;
  localparam logic [ModeWidth-1:0] ModeSoqpsk     = 5'd10;

  // DAC monitor codes produced by the trellis core
  localparam logic [DacSelWidth-1:0] DacTrellisI     = 4'd8;
  localparam logic [DacSelWidth-1:0] DacTrellisQ     = 4'd9;
  localparam logic [DacSelWidth-1:0] DacTrellisPhErr = 4'd10;
  localparam logic [DacSelWidth-1:0] DacTrellisIndex = 4'd11;

  // source selects, codes 2 and 3 fall back to the demod path
  localparam logic [1:0] SrcDemod      = 2'd0;
  localparam logic [1:0] SrcSubcarrier = 2'd1;

  // datapath reset length after a processor request
  localparam int ResetHoldCycles = 6;
  localparam int ResetCountWidth = $clog2(ResetHoldCycles + 1);

  function automatic logic isTrellisMode(input logic [ModeWidth-1:0] mode);
    return (mode == ModePcmTrellis) || (mode == ModeSoqpsk);
  endfunction

endpackage

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns

module regFile (
  input  logic                              clk,
  input  logic                              rs,
  input  logic                              awValid_i,
  output logic                              awReady_o,
  input  logic [regMapPkg::AxiAddrWidth-1:0] awAddr_i,
  input  logic                              wValid_i,
  output logic                              wReady_o,
  input  logic [regMapPkg::AxiDataWidth-1:0] wData_i,
  output logic                              bValid_o,
  input  logic                              bReady_i,
  output logic [1:0]                        bResp_o,
  input  logic                              arValid_i,
  output logic                              arReady_o,
  input  logic [regMapPkg::AxiAddrWidth-1:0] arAddr_i,
  output logic                              rValid_o,
  input  logic                              rReady_i,
  output logic [regMapPkg::AxiDataWidth-1:0] rData_o,
  output logic [1:0]                        rResp_o,
  output logic [regMapPkg::SelWidth-1:0]    dacInSel0_o,
  output logic [regMapPkg::SelWidth-1:0]    dacInSel1_o,
  output logic [regMapPkg::SelWidth-1:0]    dacInSel2_o,
  output logic [regMapPkg::SelWidth-1:0]    decInSel_o,
  output logic                              softResetReq_o
);
  import regMapPkg::*;

  logic                    wrEn;
  logic                    rdEn;
  logic [AxiDataWidth-1:0] rdMux;

  // single outstanding transaction per channel
  assign awReady_o = !bValid_o;
  assign wReady_o  = !bValid_o;
  assign arReady_o = !rValid_o;

  assign wrEn = awValid_i && wValid_i && !bValid_o;  // address and data together
  assign rdEn = arValid_i && !rValid_o;

  assign bResp_o = RespOkay;
  assign rResp_o = RespOkay;

  // ******************************
  // write channel
  // ******************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      bValid_o       <= 1'b0;
      softResetReq_o <= 1'b0;
      dacInSel0_o    <= '0;
      dacInSel1_o    <= '0;
      dacInSel2_o    <= '0;
      decInSel_o     <= '0;
    end else begin
      softResetReq_o <= wrEn && (awAddr_i == RegSoftReset);  // one cycle pulse
      if (wrEn) begin
        bValid_o <= 1'b1;
      end else if (bReady_i) begin
        bValid_o <= 1'b0;
      end
      if (wrEn) begin
        case (awAddr_i)
          RegDacInSel: begin
            dacInSel0_o <= wData_i[SelWidth-1:0];
            dacInSel1_o <= wData_i[2*SelWidth-1:SelWidth];
            dacInSel2_o <= wData_i[3*SelWidth-1:2*SelWidth];
          end
          RegDecInSel: decInSel_o <= wData_i[SelWidth-1:0];
          default: ;  // soft reset and read-only words store nothing
        endcase
      end
    end
  end

  // ******************************
  // read channel
  // ******************************
  always_comb begin
    rdMux = '0;  // unmapped offsets and soft reset read zero
    case (arAddr_i)
      RegVersion:   rdMux = VersionNumber;
      RegImageType: rdMux = ImageTypeId;
      RegDacInSel:  rdMux[3*SelWidth-1:0] = {dacInSel2_o, dacInSel1_o, dacInSel0_o};
      RegDecInSel:  rdMux[SelWidth-1:0] = decInSel_o;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      rValid_o <= 1'b0;
    end else if (rdEn) begin
      rValid_o <= 1'b1;
    end else if (rReady_i) begin
      rValid_o <= 1'b0;
    end
  end

  // data held until the master takes it
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rData_o <= rdMux;
    end
  end

endmodule

// ==== rtl/resetStretch.sv ====
`timescale 1ns/1ns

module resetStretch (
  input  logic clk,
  input  logic rs,
  input  logic softResetReq_i,
  output logic dpReset_o
);
  import signalPkg::*;

  logic [ResetCountWidth-1:0] holdCount;

  // reload on power-on reset or a processor request
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      holdCount <= ResetCountWidth'(ResetHoldCycles);
    end else if (softResetReq_i) begin
      holdCount <= ResetCountWidth'(ResetHoldCycles);
    end else if (holdCount != '0) begin
      holdCount <= holdCount - 1'b1;
    end
  end

  assign dpReset_o = (holdCount != '0);  // high for exactly ResetHoldCycles

endmodule

// ==== rtl/dacSourceMux.sv ====
`timescale 1ns/1ns

module dacSourceMux (
  input  logic                            clk,
  input  logic                            rs,
  input  logic [signalPkg::ModeWidth-1:0]   demodMode_i,
  input  logic [signalPkg::DacSelWidth-1:0] dacSelect_i,
  input  logic [regMapPkg::SelWidth-1:0]    dacInSel_i,
  input  logic [signalPkg::DemodWidth-1:0]  demodData_i,
  input  logic                            demodSync_i,
  input  logic [signalPkg::SampleWidth-1:0] trellisData_i,
  input  logic                            trellisSync_i,
  input  logic [signalPkg::SampleWidth-1:0] scData_i,
  input  logic                            scSync_i,
  output logic [signalPkg::DacWidth-1:0]    dacData_o,
  output logic                            dacSync_o
);
  import signalPkg::*;
  import regMapPkg::*;

  logic [ModeWidth-1:0]   modeReg;
  logic [DacSelWidth-1:0] selectReg;
  logic [SelWidth-1:0]    inSelReg;
  logic [DemodWidth-1:0]  demodReg;
  logic                   demodSyncReg;
  logic [SampleWidth-1:0] trellisReg;
  logic                   trellisSyncReg;
  logic [SampleWidth-1:0] scReg;
  logic                   scSyncReg;
  logic                   useTrellis;
  logic [SampleWidth-1:0] chosenData;
  logic                   chosenSync;

  // input capture
  always_ff @(posedge clk) begin
    modeReg        <= demodMode_i;
    selectReg      <= dacSelect_i;
    inSelReg       <= dacInSel_i;
    demodReg       <= demodData_i;
    demodSyncReg   <= demodSync_i;
    trellisReg     <= trellisData_i;
    trellisSyncReg <= trellisSync_i;
    scReg          <= scData_i;
    scSyncReg      <= scSync_i;
  end

  // trellis monitor codes only count in a trellis mode
  always_comb begin
    case (selectReg)
      DacTrellisI, DacTrellisQ, DacTrellisPhErr, DacTrellisIndex:
        useTrellis = isTrellisMode(modeReg);
      default: useTrellis = 1'b0;
    endcase
  end

  always_comb begin
    if (inSelReg == SrcSubcarrier) begin
      chosenData = scReg;
      chosenSync = scSyncReg;
    end else if (useTrellis) begin
      chosenData = trellisReg;
      chosenSync = trellisSyncReg;
    end else begin
      chosenData = {demodReg, {(SampleWidth-DemodWidth){1'b0}}};  // pad low bits
      chosenSync = demodSyncReg;
    end
  end

  // ******************************
  // DAC output register
  // ******************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      dacData_o <= '0;
      dacSync_o <= 1'b0;
    end else begin
      // upper bits, two's complement to offset binary
      dacData_o <= {~chosenData[SampleWidth-1], chosenData[SampleWidth-2 -: DacWidth-1]};
      dacSync_o <= chosenSync;
    end
  end

endmodule

// ==== rtl/decoderInputMux.sv ====
`timescale 1ns/1ns

module decoderInputMux (
  input  logic                          clk,
  input  logic                          rs,
  input  logic [signalPkg::ModeWidth-1:0] demodMode_i,
  input  logic [regMapPkg::SelWidth-1:0]  decInSel_i,
  input  logic                          iBit_i,
  input  logic                          qBit_i,
  input  logic                          dataSymEn_i,
  input  logic                          dataSym2xEn_i,
  input  logic                          trellisBit_i,
  input  logic                          trellisSymEn_i,
  input  logic                          trellisSym2xEn_i,
  input  logic                          scIBit_i,
  input  logic                          scQBit_i,
  input  logic                          scSymEn_i,
  input  logic                          scSym2xEn_i,
  output logic                          decI_o,
  output logic                          decQ_o,
  output logic                          decSymEn_o,
  output logic                          decSym2xEn_o
);
  import signalPkg::*;
  import regMapPkg::*;

  logic [ModeWidth-1:0] modeReg;
  logic [SelWidth-1:0]  inSelReg;
  logic iBitReg;
  logic qBitReg;
  logic dataSymEnReg;
  logic dataSym2xEnReg;
  logic trellisBitReg;
  logic trellisSymEnReg;
  logic trellisSym2xEnReg;
  logic scIBitReg;
  logic scQBitReg;
  logic scSymEnReg;
  logic scSym2xEnReg;
  logic nextI;
  logic nextQ;
  logic nextSymEn;
  logic nextSym2xEn;

  // input capture
  always_ff @(posedge clk) begin
    modeReg           <= demodMode_i;
    inSelReg          <= decInSel_i;
    iBitReg           <= iBit_i;
    qBitReg           <= qBit_i;
    dataSymEnReg      <= dataSymEn_i;
    dataSym2xEnReg    <= dataSym2xEn_i;
    trellisBitReg     <= trellisBit_i;
    trellisSymEnReg   <= trellisSymEn_i;
    trellisSym2xEnReg <= trellisSym2xEn_i;
    scIBitReg         <= scIBit_i;
    scQBitReg         <= scQBit_i;
    scSymEnReg        <= scSymEn_i;
    scSym2xEnReg      <= scSym2xEn_i;
  end

  always_comb begin
    if (inSelReg == SrcSubcarrier) begin
      nextI       = scIBitReg;
      nextQ       = scQBitReg;
      nextSymEn   = scSymEnReg;
      nextSym2xEn = scSym2xEnReg;
    end else if (isTrellisMode(modeReg)) begin
      // trellis decision arrives with inverted polarity, same bit on I and Q
      nextI       = !trellisBitReg;
      nextQ       = !trellisBitReg;
      nextSymEn   = trellisSymEnReg;
      nextSym2xEn = trellisSym2xEnReg;
    end else begin
      nextI       = iBitReg;
      nextQ       = qBitReg;
      nextSymEn   = dataSymEnReg;
      nextSym2xEn = dataSym2xEnReg;
    end
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      decI_o       <= 1'b0;
      decQ_o       <= 1'b0;
      decSymEn_o   <= 1'b0;
      decSym2xEn_o <= 1'b0;
    end else begin
      decI_o       <= nextI;
      decQ_o       <= nextQ;
      decSymEn_o   <= nextSymEn;
      decSym2xEn_o <= nextSym2xEn;
    end
  end

endmodule

// ==== rtl/dspTop.sv ====
`timescale 1ns/1ns

module dspTop (
  input  logic                              clk,
  input  logic                              rs,
  // AXI4-Lite control port
  input  logic                              awValid_i,
  output logic                              awReady_o,
  input  logic [regMapPkg::AxiAddrWidth-1:0] awAddr_i,
  input  logic                              wValid_i,
  output logic                              wReady_o,
  input  logic [regMapPkg::AxiDataWidth-1:0] wData_i,
  output logic                              bValid_o,
  input  logic                              bReady_i,
  output logic [1:0]                        bResp_o,
  input  logic                              arValid_i,
  output logic                              arReady_o,
  input  logic [regMapPkg::AxiAddrWidth-1:0] arAddr_i,
  output logic                              rValid_o,
  input  logic                              rReady_i,
  output logic [regMapPkg::AxiDataWidth-1:0] rData_o,
  output logic [1:0]                        rResp_o,
  input  logic [signalPkg::ModeWidth-1:0]    demodMode_i,
  // DAC channel 0
  input  logic [signalPkg::DacSelWidth-1:0]  dac0Select_i,
  input  logic [signalPkg::DemodWidth-1:0]   demod0Data_i,
  input  logic                              demod0Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  trellis0Data_i,
  input  logic                              trellis0Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  sc0Data_i,
  input  logic                              sc0Sync_i,
  output logic [signalPkg::DacWidth-1:0]     dac0Data_o,
  output logic                              dac0Sync_o,
  // DAC channel 1
  input  logic [signalPkg::DacSelWidth-1:0]  dac1Select_i,
  input  logic [signalPkg::DemodWidth-1:0]   demod1Data_i,
  input  logic                              demod1Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  trellis1Data_i,
  input  logic                              trellis1Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  sc1Data_i,
  input  logic                              sc1Sync_i,
  output logic [signalPkg::DacWidth-1:0]     dac1Data_o,
  output logic                              dac1Sync_o,
  // DAC channel 2
  input  logic [signalPkg::DacSelWidth-1:0]  dac2Select_i,
  input  logic [signalPkg::DemodWidth-1:0]   demod2Data_i,
  input  logic                              demod2Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  trellis2Data_i,
  input  logic                              trellis2Sync_i,
  input  logic [signalPkg::SampleWidth-1:0]  sc2Data_i,
  input  logic                              sc2Sync_i,
  output logic [signalPkg::DacWidth-1:0]     dac2Data_o,
  output logic                              dac2Sync_o,
  // bit streams for the decoder
  input  logic                              iBit_i,
  input  logic                              qBit_i,
  input  logic                              dataSymEn_i,
  input  logic                              dataSym2xEn_i,
  input  logic                              trellisBit_i,
  input  logic                              trellisSymEn_i,
  input  logic                              trellisSym2xEn_i,
  input  logic                              scIBit_i,
  input  logic                              scQBit_i,
  input  logic                              scSymEn_i,
  input  logic                              scSym2xEn_i,
  output logic                              decI_o,
  output logic                              decQ_o,
  output logic                              decSymEn_o,
  output logic                              decSym2xEn_o,
  output logic                              dacRst_o
);

  logic [regMapPkg::SelWidth-1:0] dacInSel0;
  logic [regMapPkg::SelWidth-1:0] dacInSel1;
  logic [regMapPkg::SelWidth-1:0] dacInSel2;
  logic [regMapPkg::SelWidth-1:0] decInSel;
  logic                           softResetReq;
  logic                           dpReset;

  assign dacRst_o = dpReset;  // DACs share the datapath reset

  // ******************************
  // control registers and reset
  // ******************************
  regFile u_regFile (
    .clk(clk), .rs(rs),
    .awValid_i(awValid_i), .awReady_o(awReady_o), .awAddr_i(awAddr_i),
    .wValid_i(wValid_i), .wReady_o(wReady_o), .wData_i(wData_i),
    .bValid_o(bValid_o), .bReady_i(bReady_i), .bResp_o(bResp_o),
    .arValid_i(arValid_i), .arReady_o(arReady_o), .arAddr_i(arAddr_i),
    .rValid_o(rValid_o), .rReady_i(rReady_i), .rData_o(rData_o), .rResp_o(rResp_o),
    .dacInSel0_o(dacInSel0), .dacInSel1_o(dacInSel1), .dacInSel2_o(dacInSel2),
    .decInSel_o(decInSel),
    .softResetReq_o(softResetReq)
  );

  resetStretch u_resetStretch (
    .clk(clk), .rs(rs),
    .softResetReq_i(softResetReq),
    .dpReset_o(dpReset)
  );

  // ******************************
  // DAC source selection
  // ******************************
  dacSourceMux u_dac0 (
    .clk(clk), .rs(dpReset), .demodMode_i(demodMode_i),
    .dacSelect_i(dac0Select_i), .dacInSel_i(dacInSel0),
    .demodData_i(demod0Data_i), .demodSync_i(demod0Sync_i),
    .trellisData_i(trellis0Data_i), .trellisSync_i(trellis0Sync_i),
    .scData_i(sc0Data_i), .scSync_i(sc0Sync_i),
    .dacData_o(dac0Data_o), .dacSync_o(dac0Sync_o)
  );

  dacSourceMux u_dac1 (
    .clk(clk), .rs(dpReset), .demodMode_i(demodMode_i),
    .dacSelect_i(dac1Select_i), .dacInSel_i(dacInSel1),
    .demodData_i(demod1Data_i), .demodSync_i(demod1Sync_i),
    .trellisData_i(trellis1Data_i), .trellisSync_i(trellis1Sync_i),
    .scData_i(sc1Data_i), .scSync_i(sc1Sync_i),
    .dacData_o(dac1Data_o), .dacSync_o(dac1Sync_o)
  );

  dacSourceMux u_dac2 (
    .clk(clk), .rs(dpReset), .demodMode_i(demodMode_i),
    .dacSelect_i(dac2Select_i), .dacInSel_i(dacInSel2),
    .demodData_i(demod2Data_i), .demodSync_i(demod2Sync_i),
    .trellisData_i(trellis2Data_i), .trellisSync_i(trellis2Sync_i),
    .scData_i(sc2Data_i), .scSync_i(sc2Sync_i),
    .dacData_o(dac2Data_o), .dacSync_o(dac2Sync_o)
  );

  // bit decoder input
  decoderInputMux u_decoderInputMux (
    .clk(clk), .rs(dpReset), .demodMode_i(demodMode_i), .decInSel_i(decInSel),
    .iBit_i(iBit_i), .qBit_i(qBit_i),
    .dataSymEn_i(dataSymEn_i), .dataSym2xEn_i(dataSym2xEn_i),
    .trellisBit_i(trellisBit_i), .trellisSymEn_i(trellisSymEn_i),
    .trellisSym2xEn_i(trellisSym2xEn_i),
    .scIBit_i(scIBit_i), .scQBit_i(scQBit_i),
    .scSymEn_i(scSymEn_i), .scSym2xEn_i(scSym2xEn_i),
    .decI_o(decI_o), .decQ_o(decQ_o),
    .decSymEn_o(decSymEn_o), .decSym2xEn_o(decSym2xEn_o)
  );

endmodule

// ==== tests/dspTopTb.sv ====
`timescale 1ns/1ns

module dspTopTb;
  import regMapPkg::*;
  import signalPkg::*;

  localparam string InputFile = "tests/dspTopInput.txt";

  logic clk;
  logic rs;
  logic awValid;
  logic awReady;
  logic wValid;
  logic wReady;
  logic bValid;
  logic bReady;
  logic arValid;
  logic arReady;
  logic rValid;
  logic rReady;
  logic [AxiAddrWidth-1:0] awAddr;
  logic [AxiAddrWidth-1:0] arAddr;
  logic [AxiDataWidth-1:0] wData;
  logic [AxiDataWidth-1:0] rData;
  logic [1:0]              bResp;
  logic [1:0]              rResp;
  logic [ModeWidth-1:0]    demodMode;
  logic [DacSelWidth-1:0]  dacSelect [3];
  logic [DemodWidth-1:0]   demodData [3];
  logic                    demodSync [3];
  logic [SampleWidth-1:0]  trellisData [3];
  logic                    trellisSync [3];
  logic [SampleWidth-1:0]  scData [3];
  logic                    scSync [3];
  logic [DacWidth-1:0]     dacData [3];
  logic                    dacSync [3];
  logic [10:0]             bitsIn;  // bit streams and enables, iBit in bit 0
  logic [3:0]              decOut;  // {sym2xEn, symEn, Q, I}
  logic                    dacRst;

  int          errors = 0;
  int          checks = 0;
  int          cycleCount = 0;
  int          cycleLimit = 200;
  int          rstRun = 0;
  int          lastRstRun = 0;
  bit          rstDone = 1'b0;
  logic [31:0] randState = 32'd18089;
  string       vectorLines[$];

  // expected datapath results still in flight
  int                    dueQ[$];
  logic [3*DacWidth-1:0] dacExpQ[$];
  logic [2:0]            syncExpQ[$];
  logic [3:0]            decExpQ[$];
  string                 nameQ[$];

  dspTop u_dspTop (
    .clk(clk), .rs(rs),
    .awValid_i(awValid), .awReady_o(awReady), .awAddr_i(awAddr),
    .wValid_i(wValid), .wReady_o(wReady), .wData_i(wData),
    .bValid_o(bValid), .bReady_i(bReady), .bResp_o(bResp),
    .arValid_i(arValid), .arReady_o(arReady), .arAddr_i(arAddr),
    .rValid_o(rValid), .rReady_i(rReady), .rData_o(rData), .rResp_o(rResp),
    .demodMode_i(demodMode),
    .dac0Select_i(dacSelect[0]), .demod0Data_i(demodData[0]), .demod0Sync_i(demodSync[0]),
    .trellis0Data_i(trellisData[0]), .trellis0Sync_i(trellisSync[0]),
    .sc0Data_i(scData[0]), .sc0Sync_i(scSync[0]),
    .dac0Data_o(dacData[0]), .dac0Sync_o(dacSync[0]),
    .dac1Select_i(dacSelect[1]), .demod1Data_i(demodData[1]), .demod1Sync_i(demodSync[1]),
    .trellis1Data_i(trellisData[1]), .trellis1Sync_i(trellisSync[1]),
    .sc1Data_i(scData[1]), .sc1Sync_i(scSync[1]),
    .dac1Data_o(dacData[1]), .dac1Sync_o(dacSync[1]),
    .dac2Select_i(dacSelect[2]), .demod2Data_i(demodData[2]), .demod2Sync_i(demodSync[2]),
    .trellis2Data_i(trellisData[2]), .trellis2Sync_i(trellisSync[2]),
    .sc2Data_i(scData[2]), .sc2Sync_i(scSync[2]),
    .dac2Data_o(dacData[2]), .dac2Sync_o(dacSync[2]),
    .iBit_i(bitsIn[0]), .qBit_i(bitsIn[1]),
    .dataSymEn_i(bitsIn[2]), .dataSym2xEn_i(bitsIn[3]),
    .trellisBit_i(bitsIn[4]), .trellisSymEn_i(bitsIn[5]), .trellisSym2xEn_i(bitsIn[6]),
    .scIBit_i(bitsIn[7]), .scQBit_i(bitsIn[8]),
    .scSymEn_i(bitsIn[9]), .scSym2xEn_i(bitsIn[10]),
    .decI_o(decOut[0]), .decQ_o(decOut[1]),
    .decSymEn_o(decOut[2]), .decSym2xEn_o(decOut[3]),
    .dacRst_o(dacRst)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // ******************************
  // AXI4-Lite master
  // ******************************
  task automatic axiWrite(input logic [AxiAddrWidth-1:0] addr, input logic [31:0] data,
                          input string name);
    int hold;
    @(posedge clk);
    awValid <= 1'b1;
    awAddr  <= addr;
    wValid  <= 1'b1;
    wData   <= data;
    @(negedge clk);
    while (!(awReady && wReady)) @(negedge clk);
    @(posedge clk);  // handshake edge
    awValid <= 1'b0;
    wValid  <= 1'b0;
    randState = xorshift(randState);
    hold = int'(randState % 4);
    @(negedge clk);
    checkValue({name, " bValid"}, 1, 32'(bValid));
    checkValue({name, " bResp"}, 32'(RespOkay), 32'(bResp));
    checkValue({name, " awReady while busy"}, 0, 32'(awReady));
    checkValue({name, " wReady while busy"}, 0, 32'(wReady));
    repeat (hold) begin  // response held off by the master
      @(negedge clk);
      checkValue({name, " bValid held"}, 1, 32'(bValid));
      checkValue({name, " awReady while busy"}, 0, 32'(awReady));
      checkValue({name, " wReady while busy"}, 0, 32'(wReady));
    end
    @(posedge clk);
    bReady <= 1'b1;
    @(posedge clk);
    bReady <= 1'b0;
    @(negedge clk);
    checkValue({name, " bValid cleared"}, 0, 32'(bValid));
    checkValue({name, " awReady after response"}, 1, 32'(awReady));
    checkValue({name, " wReady after response"}, 1, 32'(wReady));
  endtask

  task automatic axiRead(input logic [AxiAddrWidth-1:0] addr, output logic [31:0] data,
                         input string name);
    int hold;
    @(posedge clk);
    arValid <= 1'b1;
    arAddr  <= addr;
    @(negedge clk);
    while (!arReady) @(negedge clk);
    @(posedge clk);
    arValid <= 1'b0;
    randState = xorshift(randState);
    hold = int'(randState % 4);
    @(negedge clk);  // data one cycle after the address
    checkValue({name, " rValid"}, 1, 32'(rValid));
    checkValue({name, " rResp"}, 32'(RespOkay), 32'(rResp));
    checkValue({name, " arReady while busy"}, 0, 32'(arReady));
    data = rData;
    repeat (hold) begin
      @(negedge clk);
      checkValue({name, " rValid held"}, 1, 32'(rValid));
      checkValue({name, " rData held"}, data, rData);
      checkValue({name, " arReady while busy"}, 0, 32'(arReady));
    end
    @(posedge clk);
    rReady <= 1'b1;
    @(posedge clk);
    rReady <= 1'b0;
    @(negedge clk);
    checkValue({name, " rValid cleared"}, 0, 32'(rValid));
    checkValue({name, " arReady after response"}, 1, 32'(arReady));
  endtask

  // ******************************
  // data file
  // ******************************
  task automatic readInputFile();
    int    fd;
    string line;
    fd = $fopen(InputFile, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") vectorLines.push_back(line);
      end
      $fclose(fd);
    end
  endtask

  task automatic runLine(input string line, input int lineNo);
    string       op;
    string       name;
    int          n;
    logic [31:0] offset;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] got;
    logic [31:0] f [20];
    n = $sscanf(line, "%s %s", op, name);
    if (op == "V") begin
      n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  op, name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
    end else begin
      n = $sscanf(line, "%s %s %h %h %h", op, name, offset, data, expected);
    end
    if (op == "V" && n == 22) begin
      @(posedge clk);
      demodMode <= f[0][ModeWidth-1:0];
      for (int c = 0; c < 3; c++) begin
        dacSelect[c]   <= f[1+c][DacSelWidth-1:0];
        demodData[c]   <= f[4+c][DemodWidth-1:0];
        trellisData[c] <= f[7+c][SampleWidth-1:0];
        scData[c]      <= f[10+c][SampleWidth-1:0];
        demodSync[c]   <= f[13][3*c];  // sync column holds {sc, trellis, demod} per channel
        trellisSync[c] <= f[13][3*c+1];
        scSync[c]      <= f[13][3*c+2];
      end
      bitsIn <= f[14][10:0];
      dueQ.push_back(cycleCount + 2);  // capture register then output register
      dacExpQ.push_back({f[17][DacWidth-1:0], f[16][DacWidth-1:0], f[15][DacWidth-1:0]});
      syncExpQ.push_back(f[18][2:0]);
      decExpQ.push_back(f[19][3:0]);
      nameQ.push_back(name);
    end else if (op == "W" && n == 5) begin
      axiWrite(offset[AxiAddrWidth-1:0], data, name);
      axiRead(offset[AxiAddrWidth-1:0], got, name);
      checkValue({name, " read back"}, expected, got);
    end else if (op == "R" && n == 5) begin
      axiRead(offset[AxiAddrWidth-1:0], got, name);
      checkValue({name, " read"}, expected, got);
    end else if (op == "S" && n == 5) begin
      rstDone = 1'b0;
      axiWrite(offset[AxiAddrWidth-1:0], data, name);
      while (!rstDone) @(negedge clk);
      checkValue({name, " reset length"}, expected, 32'(lastRstRun));
    end else begin
      errors++;
      $display("line %0d of the input file cannot be parsed", lineNo);
    end
  endtask

  // ******************************
  // output monitor and timeout
  // ******************************
  always @(negedge clk) begin : monitor
    string                 name;
    logic [3*DacWidth-1:0] expDac;
    logic [2:0]            expSync;
    logic [3:0]            expDec;
    while (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
      void'(dueQ.pop_front());
      name    = nameQ.pop_front();
      expDac  = dacExpQ.pop_front();
      expSync = syncExpQ.pop_front();
      expDec  = decExpQ.pop_front();
      for (int c = 0; c < 3; c++) begin
        checkValue($sformatf("%s dac%0d", name, c),
                   32'(expDac[c*DacWidth +: DacWidth]), 32'(dacData[c]));
      end
      checkValue({name, " sync"}, 32'(expSync), 32'({dacSync[2], dacSync[1], dacSync[0]}));
      checkValue({name, " decoder"}, 32'(expDec), 32'(decOut));
    end
    if (dacRst) begin
      rstRun++;
      checkValue("dac data in reset", 0, 32'(dacData[0] | dacData[1] | dacData[2]));
      checkValue("sync and decoder in reset", 0,
                 32'({dacSync[2], dacSync[1], dacSync[0], decOut}));
    end else if (rstRun != 0) begin
      lastRstRun = rstRun;  // length of the pulse that just ended
      rstRun = 0;
      rstDone = 1'b1;
    end
    if (cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("sim failed");
      $finish;
    end else begin
      cycleCount++;
    end
  end

  initial begin
    rs = 1'b1;
    awValid = 1'b0;
    awAddr = '0;
    wValid = 1'b0;
    wData = '0;
    bReady = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    rReady = 1'b0;
    demodMode = '0;
    bitsIn = '0;
    for (int c = 0; c < 3; c++) begin
      dacSelect[c] = '0;
      demodData[c] = '0;
      demodSync[c] = 1'b0;
      trellisData[c] = '0;
      trellisSync[c] = 1'b0;
      scData[c] = '0;
      scSync[c] = 1'b0;
    end
    readInputFile();
    if (vectorLines.size() == 0) begin
      $display("input file %s is missing or holds no test lines", InputFile);
      $display("sim failed");
      $finish;
    end else begin
      cycleLimit = 60 * vectorLines.size() + 200;
      repeat (10) @(posedge clk);
      rs <= 1'b0;
      while (!rstDone) @(negedge clk);  // datapath reset runs out after rs
      foreach (vectorLines[i]) runLine(vectorLines[i], i + 1);
      while (dueQ.size() > 0) @(negedge clk);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

// ==== tests/dspTopInput.txt ====
# R/W/S name offset data expected (W reads back, S expects the reset length in cycles)
# V name mode sel0 sel1 sel2 demod0-2 trellis0-2 sc0-2 syncs bits expDac0-2 expSync expDec
R version 00 00000000 000001b1
R imageType 04 00000000 00000002
R unmapped14 14 00000000 00000000
R softResetRd 10 00000000 00000000
R unmappedFc fc 00000000 00000000
W versionRo 00 12345678 000001b1
W dacMask 08 ffffffe4 00000024
W decMask 0c fffffffe 00000002
V fmDemod 01 8 0 9 1234 0abc 3fff 2a5a5 15555 0f0f0 3c3c3 2f00f 00010 0a1 355 3234 0f00 1fff 3 5
V trellisMon 05 8 0 9 1234 0abc 3fff 2a5a5 15555 0f0f0 3c3c3 2f00f 00010 0a1 355 0a5a 0f00 2f0f 6 8
V soqpskDemod 0a 3 b 7 2001 0001 1000 3ffff 20000 1ffff 00000 3fff0 2aaaa 1ff 000 0001 1fff 3000 7 3
V soqpskMon 0a b a 8 2001 0001 1000 3ffff 20000 1ffff 00000 3fff0 2aaaa 1ff 000 1fff 1fff 3fff 7 3
W dacAllSc 08 00000015 00000015
W decSc 0c 00000001 00000001
V scFm 01 0 0 0 0000 3fff 2000 11111 22222 33333 12340 23450 34560 11c 6e2 3234 0345 1456 5 d
V scOverTrellis 05 8 9 a 0000 3fff 2000 11111 22222 33333 12340 23450 34560 11c 6e2 3234 0345 1456 5 d
W dacCh1Sc 08 00000004 00000004
W decDemod 0c 00000000 00000000
V mixedCh 01 0 0 0 0123 0456 0789 11111 22222 33333 12340 23450 34560 061 00f 2123 0345 2789 7 f
S softReset 10 00000000 00000006
R dacSelKeep 08 00000000 00000004
R decSelKeep 0c 00000000 00000000
V afterReset 05 8 0 0 1111 2222 3333 0aaaa 15555 0f0f0 3c3c3 10000 00010 000 010 2aaa 3000 1333 0 0
R unmapped20 20 00000000 00000000

// ==== verilog.f ====
rtl/regMapPkg.sv
rtl/signalPkg.sv
rtl/regFile.sv
rtl/resetStretch.sv
rtl/dacSourceMux.sv
rtl/decoderInputMux.sv
rtl/dspTop.sv
tests/dspTopTb.sv

// ==== run.sh ====
#!/bin/bash
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" \
  && rm -rf obj_dir sim.log \
  && verilator --binary --timing --assert --timescale 1ns/1ns --top-module dspTopTb \
       -f verilog.f -o dspTopSim \
  && ./obj_dir/dspTopSim | tee sim.log \
  && ! grep -q "sim failed" sim.log \
  && echo "run finished without failures" \
  || { echo "run failed or did not build"; exit 1; }
